//--- build.f
src/erx_pkg.sv
src/erx_protocol.sv
src/erx_cfg.sv
src/erx_remap.sv
src/erx_distributor.sv
src/erx_fifo.sv
src/erx_core.sv
test/erx_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := erx_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := All checks passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/erx_tb.sv
module erx_tb import erx_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int PKT_BUDGET  = 2000;           // Packets allowed for by the watchdog
   localparam int WATCHDOG_NS = PKT_BUDGET * 20 * 20;
   localparam int DRAIN_LIMIT = 500;            // Cycles to empty every FIFO
   localparam int FILL_LEVEL  = FIFO_DEPTH - WAIT_MARGIN;

   logic          clk;
   logic          reset;
   logic          rx_access;
   logic [PW-1:0] rx_packet;
   logic          rxwr_wait;
   logic          rxrd_wait;
   logic          rxrr_wait;
   logic          rx_wr_wait;
   logic          rx_rd_wait;
   logic          rxwr_access;
   logic [PW-1:0] rxwr_packet;
   logic          rxrd_access;
   logic [PW-1:0] rxrd_packet;
   logic          rxrr_access;
   logic [PW-1:0] rxrr_packet;

   logic [NCH-1:0] out_access;                  // Channel view of the outputs
   logic [NCH-1:0] out_wait;
   logic [PW-1:0]  out_packet [NCH];

   logic [31:0]    lfsr;                        // Random state
   logic           rand_waits;                  // Random back-pressure on
   logic [NCH-1:0] hold_waits;                  // Fixed waits when random is off

   logic [1:0]     sh_mode;                     // Shadow config registers
   logic [11:0]    sh_sel;
   logic [11:0]    sh_pat;
   logic [31:0]    sh_base;

   logic [PW-1:0]  exp_q [NCH][$];              // Expected packets per channel
   logic [NCH-1:0] held_valid;                  // Head was under wait last cycle
   logic [PW-1:0]  held_pkt [NCH];
   int             n_mismatch;
   int             n_other;
   int             n_checked;

   erx_core dut0 (
      .clk         (clk),
      .reset       (reset),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet),
      .rxwr_wait   (rxwr_wait),
      .rxrd_wait   (rxrd_wait),
      .rxrr_wait   (rxrr_wait),
      .rx_wr_wait  (rx_wr_wait),
      .rx_rd_wait  (rx_rd_wait),
      .rxwr_access (rxwr_access),
      .rxwr_packet (rxwr_packet),
      .rxrd_access (rxrd_access),
      .rxrd_packet (rxrd_packet),
      .rxrr_access (rxrr_access),
      .rxrr_packet (rxrr_packet)
   );

   assign out_access[CH_WR] = rxwr_access;
   assign out_access[CH_RD] = rxrd_access;
   assign out_access[CH_RR] = rxrr_access;
   assign out_wait[CH_WR]   = rxwr_wait;
   assign out_wait[CH_RD]   = rxrd_wait;
   assign out_wait[CH_RR]   = rxrr_wait;
   assign out_packet[CH_WR] = rxwr_packet;
   assign out_packet[CH_RD] = rxrd_packet;
   assign out_packet[CH_RR] = rxrr_packet;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;                   // 20 ns period
   end

   initial begin
      #WATCHDOG_NS;
      $display("Timeout: run exceeded %0d ns before all packets were checked", WATCHDOG_NS);
      $display("Checks failed");
      $finish;
   end

   // Right shifting Galois LFSR with taps x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);                // One step per bit
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [1:0] classify(input logic [PW-1:0] pkt);
      logic [31:0] dst;
      dst = pkt[DST_LSB +: DST_W];
      if (!pkt[WRITE_LSB]) return CLS_RD;
      if (dst[31:20] == CHIP_ID) return CLS_CFG;  // Own id space
      if (pkt[CTRL_LSB +: CTRL_W] == CTRL_RR) return CLS_RR;
      return CLS_WR;
   endfunction

   // Class seen from an output packet
   function automatic logic [1:0] out_class(input logic [PW-1:0] pkt);
      if (!pkt[WRITE_LSB]) return CLS_RD;
      if (pkt[CTRL_LSB +: CTRL_W] == CTRL_RR) return CLS_RR;
      return CLS_WR;
   endfunction

   function automatic logic [1:0] chan_class(input int ch);
      case (ch)
         CH_RD:   return CLS_RD;
         CH_RR:   return CLS_RR;
         default: return CLS_WR;
      endcase
   endfunction

   function automatic logic [PW-1:0] predict(input logic [PW-1:0] pkt, input logic [1:0] cls);
      logic [PW-1:0] p;
      logic [31:0]   dst;
      p   = pkt;
      dst = pkt[DST_LSB +: DST_W];
      if (cls == CLS_WR || cls == CLS_RD) begin
         if (sh_mode == REMAP_STATIC) begin
            for (int i = 0; i < 12; i++) begin
               if (sh_sel[i]) dst[20+i] = sh_pat[i];  // Selected id bit forced
            end
         end else if (sh_mode == REMAP_DYNAMIC) begin
            dst = dst + sh_base;                // Wraps at 32 bits
         end
      end
      p[DST_LSB +: DST_W] = dst;
      return p;
   endfunction

   function automatic logic [PW-1:0] cfg_packet(input logic [7:0] ofs, input logic [31:0] data);
      logic [PW-1:0] p;
      p = '0;
      p[WRITE_LSB]             = 1'b1;
      p[DST_LSB +: DST_W]      = {CHIP_ID, 12'h000, ofs};
      p[DATA_LSB +: DATA_W]    = data;
      return p;
   endfunction

   function automatic logic [PW-1:0] make_packet(input logic [1:0] cls);
      logic [PW-1:0] p;
      logic [31:0]   dst;
      logic [3:0]    ctrl;
      logic [7:0]    ofs;
      if (cls == CLS_CFG) begin
         case (2'(rand_bits(2)))
            2'd0:    ofs = CFG_REMAP_SEL;
            2'd1:    ofs = CFG_REMAP_PATTERN;
            2'd2:    ofs = CFG_REMAP_BASE;
            default: ofs = 8'(rand_bits(8));    // Mostly unmapped
         endcase
         return cfg_packet(ofs, rand_bits(32));
      end
      p = '0;
      p[SRC_LSB +: SRC_W]   = rand_bits(32);
      p[DATA_LSB +: DATA_W] = rand_bits(32);
      p[DMODE_LSB +: DMODE_W] = 2'(rand_bits(2));
      dst  = rand_bits(32);
      ctrl = 4'(rand_bits(4));
      if (cls != CLS_RD) begin
         p[WRITE_LSB] = 1'b1;
         if (dst[31:20] == CHIP_ID) dst[20] = ~dst[20];  // Keep out of config space
         if (cls == CLS_RR) begin
            ctrl = CTRL_RR;
         end else if (ctrl == CTRL_RR) begin
            ctrl = ctrl ^ 4'b0001;
         end
      end
      p[DST_LSB +: DST_W]   = dst;
      p[CTRL_LSB +: CTRL_W] = ctrl;
      return p;
   endfunction

   task automatic check_packet(input logic [PW-1:0] got, input logic [PW-1:0] exp,
                               input string msg);
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic check_class(input logic [1:0] got, input logic [1:0] exp, input string msg);
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH at %0t: %s, class %0d expected %0d", $time, msg, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string msg);
      if (got !== exp) begin
         n_mismatch++;
         $display("MISMATCH at %0t: %s, got %b expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic report_error(input string msg);
      n_other++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   // One clock of link drive plus the channel waits
   task automatic tick(input logic acc, input logic [PW-1:0] pkt);
      @(posedge clk);
      rx_access <= acc;
      rx_packet <= pkt;
      if (rand_waits) begin
         rxwr_wait <= (rand_bits(2) == 3);      // Held about a quarter of cycles
         rxrd_wait <= (rand_bits(2) == 3);
         rxrr_wait <= (rand_bits(2) == 3);
      end else begin
         rxwr_wait <= hold_waits[CH_WR];
         rxrd_wait <= hold_waits[CH_RD];
         rxrr_wait <= hold_waits[CH_RR];
      end
   endtask

   task automatic idle(input int n);
      repeat (n) tick(1'b0, '0);
   endtask

   task automatic model_accept(input logic [PW-1:0] pkt, input logic [1:0] cls);
      logic [31:0] data;
      data = pkt[DATA_LSB +: DATA_W];
      case (cls)
         CLS_CFG: begin
            case (pkt[DST_LSB +: CFG_OFS_W])
               CFG_REMAP_MODE:    sh_mode = data[1:0];
               CFG_REMAP_SEL:     sh_sel  = data[11:0];
               CFG_REMAP_PATTERN: sh_pat  = data[11:0];
               CFG_REMAP_BASE:    sh_base = data;
               default:           ;             // Ignored offset
            endcase
         end
         CLS_RD:  exp_q[CH_RD].push_back(predict(pkt, cls));
         CLS_RR:  exp_q[CH_RR].push_back(predict(pkt, cls));
         default: exp_q[CH_WR].push_back(predict(pkt, cls));
      endcase
   endtask

   task automatic send(input logic [PW-1:0] pkt);
      logic [1:0] cls;
      logic       blocked;
      cls     = classify(pkt);
      blocked = 1'b1;
      while (blocked) begin
         @(negedge clk);
         blocked = (cls == CLS_RD) ? rx_rd_wait : rx_wr_wait;  // Link obeys its wait
         if (blocked) tick(1'b0, '0);
      end
      tick(1'b1, pkt);
      model_accept(pkt, cls);
      if (cls == CLS_CFG) idle(3);              // Settle before next packet
   endtask

   task automatic gap();
      if (rand_bits(3) == 0) idle(1 + int'(rand_bits(2)));
   endtask

   task automatic drain();
      int cycles;
      int left;
      rand_waits = 1'b0;
      hold_waits = '0;
      cycles     = 0;
      left       = exp_q[CH_WR].size() + exp_q[CH_RD].size() + exp_q[CH_RR].size();
      while (left != 0 && cycles < DRAIN_LIMIT) begin
         idle(1);
         cycles++;
         left = exp_q[CH_WR].size() + exp_q[CH_RD].size() + exp_q[CH_RR].size();
      end
      idle(2);                                  // Last pops land
      if (left != 0) report_error($sformatf("%0d packets never came out of the DUT", left));
   endtask

   // Link wait rises once a held channel has FILL_LEVEL entries
   task automatic fill_check(input int ch);
      logic got;
      hold_waits     = '0;
      hold_waits[ch] = 1'b1;
      idle(1);
      for (int n = 1; n <= FILL_LEVEL; n++) begin
         send(make_packet(chan_class(ch)));
         idle(3);                               // Strobe to FIFO write
         @(negedge clk);
         got = (ch == CH_RD) ? rx_rd_wait : rx_wr_wait;
         check_bit(got, (n >= FILL_LEVEL),
                   $sformatf("link wait for channel %0d after %0d packets", ch, n));
      end
      drain();
   endtask

   always @(negedge clk) begin
      logic [PW-1:0] exp_pkt;
      if (reset) begin
         held_valid = '0;
      end else begin
         for (int ch = 0; ch < NCH; ch++) begin
            if (held_valid[ch]) begin
               if (!out_access[ch]) begin
                  report_error($sformatf("channel %0d lost its head while waiting", ch));
               end else begin
                  check_packet(out_packet[ch], held_pkt[ch],
                               $sformatf("held head on channel %0d", ch));
               end
            end
            held_valid[ch] = out_access[ch] && out_wait[ch];
            held_pkt[ch]   = out_packet[ch];
            if (out_access[ch] && !out_wait[ch]) begin  // Pops on the next edge
               if (exp_q[ch].size() == 0) begin
                  report_error($sformatf("unexpected packet on channel %0d", ch));
               end else begin
                  exp_pkt = exp_q[ch].pop_front();
                  check_packet(out_packet[ch], exp_pkt, $sformatf("packet on channel %0d", ch));
                  check_class(out_class(out_packet[ch]), chan_class(ch),
                              $sformatf("class on channel %0d", ch));
                  n_checked++;
               end
            end
         end
      end
   end

   initial begin
      lfsr       = 32'd81932;
      reset      = 1'b1;
      rx_access  = 1'b0;
      rx_packet  = '0;
      rxwr_wait  = 1'b0;
      rxrd_wait  = 1'b0;
      rxrr_wait  = 1'b0;
      rand_waits = 1'b0;
      hold_waits = '0;
      sh_mode    = REMAP_NONE;
      sh_sel     = '0;
      sh_pat     = '0;
      sh_base    = '0;
      held_valid = '0;
      n_mismatch = 0;
      n_other    = 0;
      n_checked  = 0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_bit(rxwr_access, 1'b0, "rxwr_access after reset");
      check_bit(rxrd_access, 1'b0, "rxrd_access after reset");
      check_bit(rxrr_access, 1'b0, "rxrr_access after reset");
      check_bit(rx_wr_wait, 1'b0, "rx_wr_wait after reset");
      check_bit(rx_rd_wait, 1'b0, "rx_rd_wait after reset");

      for (int i = 0; i < 40; i++) send(make_packet(2'(rand_bits(2) % 3)));  // Remap off
      drain();

      rand_waits = 1'b1;                        // All classes under back-pressure
      for (int i = 0; i < 400; i++) begin
         send(make_packet(2'(rand_bits(2))));
         gap();
      end
      drain();

      send(cfg_packet(CFG_REMAP_SEL, rand_bits(32)));
      send(cfg_packet(CFG_REMAP_PATTERN, rand_bits(32)));
      send(cfg_packet(CFG_REMAP_MODE, 32'(REMAP_STATIC)));
      rand_waits = 1'b1;
      for (int i = 0; i < 300; i++) begin
         send(make_packet(2'(rand_bits(2) % 3)));
         gap();
      end
      drain();

      send(cfg_packet(CFG_REMAP_BASE, rand_bits(32)));
      send(cfg_packet(CFG_REMAP_MODE, 32'(REMAP_DYNAMIC)));
      rand_waits = 1'b1;
      for (int i = 0; i < 300; i++) begin
         send(make_packet(2'(rand_bits(2) % 3)));
         gap();
      end
      drain();

      fill_check(CH_WR);
      fill_check(CH_RD);
      fill_check(CH_RR);

      $display("Summary: %0d mismatches, %0d other errors, %0d packets checked",
               n_mismatch, n_other, n_checked);
      if (n_mismatch == 0 && n_other == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- src/erx_core.sv
module erx_core import erx_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          rx_access,
   input  logic [PW-1:0] rx_packet,
   input  logic          rxwr_wait,
   input  logic          rxrd_wait,
   input  logic          rxrr_wait,
   output logic          rx_wr_wait,
   output logic          rx_rd_wait,
   output logic          rxwr_access,
   output logic [PW-1:0] rxwr_packet,
   output logic          rxrd_access,
   output logic [PW-1:0] rxrd_packet,
   output logic          rxrr_access,
   output logic [PW-1:0] rxrr_packet
);

   logic          p_access;                     // Protocol stage out
   logic [1:0]    p_class;
   logic [PW-1:0] p_packet;

   logic [1:0]    remap_mode;                   // Config levels
   logic [11:0]   remap_sel;
   logic [11:0]   remap_pattern;
   logic [31:0]   remap_base;

   logic          r_access;                     // Remap stage out
   logic [1:0]    r_class;
   logic [PW-1:0] r_packet;

   logic [NCH-1:0]            fifo_push;
   logic [PW-1:0]             fifo_data;
   logic [NCH-1:0][FIFO_AW:0] fifo_free;
   logic [NCH-1:0]            ch_wait;          // Per channel back-pressure
   logic [NCH-1:0]            ch_access;
   logic [PW-1:0]             ch_packet [NCH];

   erx_protocol u_protocol (
      .clk       (clk),
      .reset     (reset),
      .rx_access (rx_access),
      .rx_packet (rx_packet),
      .p_access  (p_access),
      .p_class   (p_class),
      .p_packet  (p_packet)
   );

   erx_cfg u_cfg (
      .clk           (clk),
      .reset         (reset),
      .p_access      (p_access),
      .p_class       (p_class),
      .p_packet      (p_packet),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base)
   );

   erx_remap u_remap (
      .clk           (clk),
      .reset         (reset),
      .p_access      (p_access),
      .p_class       (p_class),
      .p_packet      (p_packet),
      .remap_mode    (remap_mode),
      .remap_sel     (remap_sel),
      .remap_pattern (remap_pattern),
      .remap_base    (remap_base),
      .r_access      (r_access),
      .r_class       (r_class),
      .r_packet      (r_packet)
   );

   erx_distributor u_distributor (
      .r_access   (r_access),
      .r_class    (r_class),
      .r_packet   (r_packet),
      .fifo_free  (fifo_free),
      .fifo_push  (fifo_push),
      .fifo_data  (fifo_data),
      .rx_wr_wait (rx_wr_wait),
      .rx_rd_wait (rx_rd_wait)
   );

   assign ch_wait[CH_WR] = rxwr_wait;
   assign ch_wait[CH_RD] = rxrd_wait;
   assign ch_wait[CH_RR] = rxrr_wait;

   for (genvar ch = 0; ch < NCH; ch++) begin : g_fifo
      erx_fifo u_fifo (
         .clk     (clk),
         .reset   (reset),
         .push    (fifo_push[ch]),
         .data_in (fifo_data),
         .wait_in (ch_wait[ch]),
         .free    (fifo_free[ch]),
         .access  (ch_access[ch]),
         .packet  (ch_packet[ch])
      );
   end

   assign rxwr_access = ch_access[CH_WR];        // Channel index to named ports
   assign rxwr_packet = ch_packet[CH_WR];
   assign rxrd_access = ch_access[CH_RD];
   assign rxrd_packet = ch_packet[CH_RD];
   assign rxrr_access = ch_access[CH_RR];
   assign rxrr_packet = ch_packet[CH_RR];

endmodule

//--- src/erx_fifo.sv
module erx_fifo import erx_pkg::*; (
   input  logic             clk,
   input  logic             reset,
   input  logic             push,
   input  logic [PW-1:0]    data_in,
   input  logic             wait_in,
   output logic [FIFO_AW:0] free,
   output logic             access,
   output logic [PW-1:0]    packet
);

   logic [PW-1:0]      mem [FIFO_DEPTH];        // Packet storage
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;                   // Entries held
   logic               full;
   logic               pop;
   logic               wr_en;

   assign full   = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign access = (count != '0);               // Fallthrough shows the head
   assign packet = mem[rd_ptr];
   assign pop    = access && !wait_in;          // Consumed when not held
   assign wr_en  = push && (!full || pop);      // Full slot frees on same edge
   assign free   = (FIFO_AW+1)'(FIFO_DEPTH) - count;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= data_in;
      end
   end

   // Pointers wrap with depth a power of two
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // Idle or push with pop
         endcase
      end
   end

endmodule

//--- src/erx_distributor.sv
module erx_distributor import erx_pkg::*; (
   input  logic                        r_access,
   input  logic [1:0]                  r_class,
   input  logic [PW-1:0]               r_packet,
   input  logic [NCH-1:0][FIFO_AW:0]   fifo_free,
   output logic [NCH-1:0]              fifo_push,
   output logic [PW-1:0]               fifo_data,
   output logic                        rx_wr_wait,
   output logic                        rx_rd_wait
);

   logic [NCH-1:0] low_space;                   // Free at or under margin per channel

   // Class to channel steering
   always_comb begin
      fifo_push = '0;
      if (r_access) begin
         case (r_class)
            CLS_WR:  fifo_push[CH_WR] = 1'b1;
            CLS_RD:  fifo_push[CH_RD] = 1'b1;
            CLS_RR:  fifo_push[CH_RR] = 1'b1;
            default: fifo_push = '0;            // Config never gets here
         endcase
      end
   end

   assign fifo_data = r_packet;                 // Shared by all FIFOs

   always_comb begin
      for (int ch = 0; ch < NCH; ch++) begin
         low_space[ch] = (fifo_free[ch] <= (FIFO_AW+1)'(WAIT_MARGIN));
      end
   end

   // Responses share the write wait since both arrive as writes
   assign rx_wr_wait = low_space[CH_WR] || low_space[CH_RR];
   assign rx_rd_wait = low_space[CH_RD];

endmodule

//--- src/erx_remap.sv
module erx_remap import erx_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          p_access,
   input  logic [1:0]    p_class,
   input  logic [PW-1:0] p_packet,
   input  logic [1:0]    remap_mode,
   input  logic [11:0]   remap_sel,
   input  logic [11:0]   remap_pattern,
   input  logic [31:0]   remap_base,
   output logic          r_access,
   output logic [1:0]    r_class,
   output logic [PW-1:0] r_packet
);

   logic [AW-1:0] dst_in;                       // Original destination
   logic [AW-1:0] dst_static;                   // High bits forced by select mask
   logic [AW-1:0] dst_dynamic;                  // Base offset added
   logic [AW-1:0] dst_out;
   logic          do_remap;                     // Only writes and read requests
   logic [PW-1:0] packet_out;

   assign dst_in   = p_packet[DST_LSB +: DST_W];
   assign do_remap = (p_class == CLS_WR) || (p_class == CLS_RD);

   assign dst_static = {(dst_in[AW-1 -: ID_W] & ~remap_sel) | (remap_pattern & remap_sel),
                        dst_in[AW-ID_W-1:0]};
   assign dst_dynamic = dst_in + remap_base;    // Wraps modulo 2^32

   always_comb begin
      dst_out = dst_in;
      if (do_remap) begin
         case (remap_mode)
            REMAP_STATIC:  dst_out = dst_static;
            REMAP_DYNAMIC: dst_out = dst_dynamic;
            default:       dst_out = dst_in;    // None and mode 3
         endcase
      end
   end

   always_comb begin
      packet_out = p_packet;
      packet_out[DST_LSB +: DST_W] = dst_out;   // Splice new address in
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         r_access <= 1'b0;
      end else begin
         r_access <= p_access && (p_class != CLS_CFG); // Config packets end here
      end
   end

   always_ff @(posedge clk) begin
      r_class  <= p_class;
      r_packet <= packet_out;
   end

endmodule

//--- src/erx_cfg.sv
module erx_cfg import erx_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          p_access,
   input  logic [1:0]    p_class,
   input  logic [PW-1:0] p_packet,
   output logic [1:0]    remap_mode,
   output logic [11:0]   remap_sel,
   output logic [11:0]   remap_pattern,
   output logic [31:0]   remap_base
);

   logic                 cfg_we;                // Config write this cycle
   logic [CFG_OFS_W-1:0] cfg_ofs;               // Register offset
   logic [DATA_W-1:0]    cfg_data;

   assign cfg_we   = p_access && (p_class == CLS_CFG);
   assign cfg_ofs  = p_packet[DST_LSB +: CFG_OFS_W];
   assign cfg_data = p_packet[DATA_LSB +: DATA_W];

   // Remap settings hold until rewritten
   always_ff @(posedge clk) begin
      if (reset) begin
         remap_mode    <= REMAP_NONE;
         remap_sel     <= '0;
         remap_pattern <= '0;
         remap_base    <= '0;
      end else if (cfg_we) begin
         case (cfg_ofs)
            CFG_REMAP_MODE: begin
               remap_mode <= cfg_data[1:0];      // Low two bits only
            end
            CFG_REMAP_SEL: begin
               remap_sel <= cfg_data[11:0];      // Mask over dstaddr[31:20]
            end
            CFG_REMAP_PATTERN: begin
               remap_pattern <= cfg_data[11:0];
            end
            CFG_REMAP_BASE: begin
               remap_base <= cfg_data;           // Full 32 bit offset
            end
            default: begin
               // Unmapped offsets fall through silently
            end
         endcase
      end
   end

endmodule

//--- src/erx_protocol.sv
module erx_protocol import erx_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          rx_access,
   input  logic [PW-1:0] rx_packet,
   output logic          p_access,
   output logic [1:0]    p_class,
   output logic [PW-1:0] p_packet
);

   logic [AW-1:0]     dstaddr;                  // Incoming destination
   logic [CTRL_W-1:0] ctrlmode;
   logic              is_write;
   logic              is_local;                 // Hits this chip's id space
   logic [1:0]        cls;                      // Decoded class, pre-register

   assign dstaddr  = rx_packet[DST_LSB +: DST_W];
   assign ctrlmode = rx_packet[CTRL_LSB +: CTRL_W];
   assign is_write = rx_packet[WRITE_LSB +: WRITE_W];
   assign is_local = (dstaddr[AW-1 -: ID_W] == CHIP_ID);

   always_comb begin
      if (!is_write) begin
         cls = CLS_RD;                          // Anything not a write is a read
      end else if (is_local) begin
         cls = CLS_CFG;                         // Local register space
      end else if (ctrlmode == CTRL_RR) begin
         cls = CLS_RR;                          // Tagged write coming back
      end else begin
         cls = CLS_WR;
      end
   end

   // Registered link strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         p_access <= 1'b0;
      end else begin
         p_access <= rx_access;
      end
   end

   always_ff @(posedge clk) begin
      p_class  <= cls;                          // Qualified by p_access
      p_packet <= rx_packet;
   end

endmodule

//--- src/erx_pkg.sv
package erx_pkg;

   localparam int PW          = 104;           // Packet width
   localparam int AW          = 32;            // Address width

   localparam int WRITE_LSB   = 0;             // Write flag
   localparam int WRITE_W     = 1;
   localparam int DMODE_LSB   = 1;             // Datamode
   localparam int DMODE_W     = 2;
   localparam int CTRL_LSB    = 3;             // Ctrlmode
   localparam int CTRL_W      = 4;
   localparam int DST_LSB     = 8;             // Destination address
   localparam int DST_W       = 32;
   localparam int DATA_LSB    = 40;            // Write data
   localparam int DATA_W      = 32;
   localparam int SRC_LSB     = 72;            // Source address
   localparam int SRC_W       = 32;

   localparam int         ID_W    = 12;        // Chip id lives in dstaddr[31:20]
   localparam logic [11:0] CHIP_ID = 12'h999;

   localparam logic [1:0] CLS_WR  = 2'd0;      // Remote write
   localparam logic [1:0] CLS_RD  = 2'd1;      // Read request
   localparam logic [1:0] CLS_RR  = 2'd2;      // Read response
   localparam logic [1:0] CLS_CFG = 2'd3;      // Local config write

   localparam logic [3:0] CTRL_RR = 4'b1000;   // Ctrlmode tag for read responses

   localparam logic [1:0] REMAP_NONE    = 2'd0;
   localparam logic [1:0] REMAP_STATIC  = 2'd1;
   localparam logic [1:0] REMAP_DYNAMIC = 2'd2; // Mode 3 behaves as none

   localparam int         CFG_OFS_W         = 8; // Offset taken from dstaddr[7:0]
   localparam logic [7:0] CFG_REMAP_MODE    = 8'h00;
   localparam logic [7:0] CFG_REMAP_SEL     = 8'h04;
   localparam logic [7:0] CFG_REMAP_PATTERN = 8'h08;
   localparam logic [7:0] CFG_REMAP_BASE    = 8'h0C;

   localparam int NCH   = 3;                   // Output channels
   localparam int CH_WR = 0;
   localparam int CH_RD = 1;
   localparam int CH_RR = 2;

   localparam int FIFO_DEPTH  = 8;
   localparam int FIFO_AW     = 3;
   localparam int WAIT_MARGIN = 3;             // Two stages in flight plus one

endpackage
